//--- sources.f
logic/aluPkg.sv
logic/rotator.sv
logic/simpleOps.sv
logic/intDivider.sv
logic/intSqrt.sv
logic/alu.sv
test/aluTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aluTb -f sources.f -o aluSim

output=$(./obj_dir/aluSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

//--- test/aluTb.sv
`default_nettype none

module aluTb;

    import aluPkg::*;

    localparam int Timeout = 100;

    localparam funcCode_t FastCodes [16] = '{
        FnAdd, FnSub, FnMul, FnShl, FnShr,
        FnEq, FnNe, FnGt, FnGe, FnLt, FnLe,
        FnNot, FnAnd, FnOr, FnXor, FnXnor
    };

    // Fixed operand pairs, several of them aimed at the shift limit
    localparam word_t FixedA [7] = '{32'h0, 32'hFFFFFFFF, 32'h12345678, 32'h80000000,
                                     32'hDEADBEEF, 32'hCAFEF00D, 32'hA5A5A5A5};
    localparam word_t FixedB [7] = '{32'h0, 32'h1, 32'h9ABCDEF0, 32'd31,
                                     32'd32, 32'd33, 32'hA5A5A5A5};

    logic      Schreibsignal;
    logic      i_rst;
    logic      i_start;
    funcCode_t i_funcCode;
    word_t     i_opA;
    word_t     i_opB;
    word_t     o_result;
    logic      o_done;
    logic      o_busy;
    logic      o_illegal;

    int        seed;
    int        cycles;
    logic      busyGap;

    alu u_alu (
        .Schreibsignal (Schreibsignal),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_funcCode    (i_funcCode),
        .i_opA         (i_opA),
        .i_opB         (i_opB),
        .o_result      (o_result),
        .o_done        (o_done),
        .o_busy        (o_busy),
        .o_illegal     (o_illegal)
    );

    always #20 Schreibsignal = ~Schreibsignal;

    task automatic stopRun(string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic checkWord(string name, word_t got, word_t expected);
        if (got !== expected) begin
            stopRun($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    task automatic checkFlag(string name, logic got, logic expected);
        if (got !== expected) begin
            stopRun($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic word_t rotateModel(word_t a, int amount, bit right);
        word_t r;
        r = a;
        // One bit position per step
        for (int i = 0; i < amount; i++) begin
            r = right ? {r[0], r[WordWidth-1:1]} : {r[WordWidth-2:0], r[WordWidth-1]};
        end
        return r;
    endfunction

    function automatic word_t sqrtModel(word_t a);
        logic [63:0] root;
        logic [63:0] trial;
        root = '0;
        // Keep each root bit whose square still fits under the radicand
        for (int bitPos = WordWidth / 2 - 1; bitPos >= 0; bitPos--) begin
            trial = root | (64'd1 << bitPos);
            if (trial * trial <= {32'd0, a}) begin
                root = trial;
            end
        end
        return root[WordWidth-1:0];
    endfunction

    function automatic logic modelIllegal(logic [5:0] code);
        case (code)
            FnAdd, FnSub, FnMul, FnSqrt, FnDiv, FnMod, FnShl, FnShr, FnRotl, FnRotr,
            FnEq, FnNe, FnGt, FnGe, FnLt, FnLe,
            FnNot, FnAnd, FnOr, FnXor, FnXnor: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t modelResult(logic [5:0] code, word_t a, word_t b);
        case (code)
            FnAdd:  return a + b;
            FnSub:  return a - b;
            FnMul:  return a * b;
            FnSqrt: return sqrtModel(a);
            FnDiv:  return (b == 32'd0) ? 32'hFFFFFFFF : a / b;
            FnMod:  return (b == 32'd0) ? a : a % b;
            FnShl:  return (b >= 32'd32) ? 32'd0 : a << b;
            FnShr:  return (b >= 32'd32) ? 32'd0 : a >> b;
            FnRotl: return rotateModel(a, int'(b[4:0]), 1'b0);
            FnRotr: return rotateModel(a, int'(b[4:0]), 1'b1);
            FnEq:   return (a == b) ? 32'd1 : 32'd0;
            FnNe:   return (a != b) ? 32'd1 : 32'd0;
            FnGt:   return (a > b) ? 32'd1 : 32'd0;
            FnGe:   return (a >= b) ? 32'd1 : 32'd0;
            FnLt:   return (a < b) ? 32'd1 : 32'd0;
            FnLe:   return (a <= b) ? 32'd1 : 32'd0;
            FnNot:  return ~a;
            FnAnd:  return a & b;
            FnOr:   return a | b;
            FnXor:  return a ^ b;
            FnXnor: return ~(a ^ b);
            default: return 32'd0;
        endcase
    endfunction

    // Pulse start for one cycle, then wait for done at falling edges
    task automatic runOp(funcCode_t code, word_t a, word_t b);
        @(posedge Schreibsignal);
        i_start    <= 1'b1;
        i_funcCode <= code;
        i_opA      <= a;
        i_opB      <= b;
        @(posedge Schreibsignal);
        i_start <= 1'b0;
        cycles  = 0;
        busyGap = 1'b0;
        do begin
            @(negedge Schreibsignal);
            cycles++;
            if (o_done !== 1'b1 && o_busy !== 1'b1) begin
                busyGap = 1'b1;
            end
            if (o_done !== 1'b1 && cycles >= Timeout) begin
                stopRun($sformatf("Timeout: no o_done within %0d cycles of start", Timeout));
            end
        end while (o_done !== 1'b1);
    endtask

    task automatic checkOp(funcCode_t code, word_t a, word_t b);
        int maxCycles;
        runOp(code, a, b);
        checkWord("o_result", o_result, modelResult(code, a, b));
        checkFlag("o_illegal", o_illegal, modelIllegal(code));
        checkFlag("o_busy", o_busy, 1'b0);
        if (code == FnDiv || code == FnMod || code == FnSqrt) begin
            maxCycles = (code == FnSqrt) ? WordWidth / 2 + 2 : WordWidth + 2;
            if (busyGap) begin
                stopRun("o_busy went low before o_done on a multi-cycle operation");
            end
            if (cycles < 2 || cycles > maxCycles) begin
                stopRun($sformatf("Multi-cycle operation took %0d cycles", cycles));
            end
        end else if (cycles != 1) begin
            stopRun($sformatf("One-cycle operation took %0d cycles instead of 1", cycles));
        end
    endtask

    task automatic testOneCycle();
        word_t a;
        word_t b;
        foreach (FastCodes[c]) begin
            foreach (FixedA[k]) begin
                checkOp(FastCodes[c], FixedA[k], FixedB[k]);
            end
            for (int i = 0; i < 6; i++) begin
                a = word_t'($random(seed));
                b = word_t'($random(seed));
                checkOp(FastCodes[c], a, b);
                // Small amounts so shifts see both sides of 32
                checkOp(FastCodes[c], a, b & 32'h3F);
            end
        end
    endtask

    task automatic testRotates();
        word_t a;
        a = 32'h8000_0001;
        foreach (FixedA[k]) begin
            checkOp(FnRotl, FixedA[k] ^ a, 32'd0);
            checkOp(FnRotl, FixedA[k] ^ a, 32'd1);
            checkOp(FnRotl, FixedA[k] ^ a, 32'd31);
            checkOp(FnRotr, FixedA[k] ^ a, 32'd0);
            checkOp(FnRotr, FixedA[k] ^ a, 32'd1);
            checkOp(FnRotr, FixedA[k] ^ a, 32'd31);
        end
        for (int i = 0; i < 10; i++) begin
            checkOp(FnRotl, word_t'($random(seed)), word_t'($random(seed)));
            checkOp(FnRotr, word_t'($random(seed)), word_t'($random(seed)));
        end
    endtask

    task automatic testDivide();
        word_t a;
        word_t b;
        for (int i = 0; i < 6; i++) begin
            a = word_t'($random(seed));
            b = word_t'($random(seed)) & 32'h0000_FFFF;
            checkOp(FnDiv, a, b);
            checkOp(FnMod, a, b);
            checkOp(FnDiv, a, word_t'($random(seed)));
        end
        // Dividend below divisor, then division by zero
        checkOp(FnDiv, 32'd7, 32'd1000);
        checkOp(FnMod, 32'd7, 32'd1000);
        checkOp(FnDiv, 32'h1234_5678, 32'd0);
        checkOp(FnMod, 32'h1234_5678, 32'd0);
        checkOp(FnDiv, 32'hFFFF_FFFF, 32'd1);
    endtask

    task automatic testSqrt();
        checkOp(FnSqrt, 32'd0, 32'd0);
        checkOp(FnSqrt, 32'd1, 32'd0);
        checkOp(FnSqrt, 32'd49, 32'd0);
        checkOp(FnSqrt, 32'd65536, 32'd0);
        checkOp(FnSqrt, 32'hFFFE_0001, 32'd0);
        checkOp(FnSqrt, 32'hFFFF_FFFF, 32'd0);
        for (int i = 0; i < 8; i++) begin
            checkOp(FnSqrt, word_t'($random(seed)), 32'd0);
        end
    endtask

    task automatic testStartWhileBusy();
        int waitCount;
        @(posedge Schreibsignal);
        i_start    <= 1'b1;
        i_funcCode <= FnSqrt;
        i_opA      <= 32'd1000000;
        i_opB      <= 32'd0;
        @(posedge Schreibsignal);
        i_start   <= 1'b0;
        waitCount = 0;
        do begin
            @(negedge Schreibsignal);
            waitCount++;
            if (o_busy !== 1'b1 && waitCount >= Timeout) begin
                stopRun("Timeout: o_busy never rose after a square root start");
            end
        end while (o_busy !== 1'b1);
        // Second start lands while the first one runs
        @(posedge Schreibsignal);
        i_start <= 1'b1;
        i_opA   <= 32'd81;
        @(posedge Schreibsignal);
        i_start   <= 1'b0;
        waitCount = 0;
        do begin
            @(negedge Schreibsignal);
            waitCount++;
            if (o_done !== 1'b1 && waitCount >= Timeout) begin
                stopRun("Timeout: no o_done for the first square root");
            end
        end while (o_done !== 1'b1);
        checkWord("o_result", o_result, sqrtModel(32'd1000000));
        repeat (WordWidth + 4) begin
            @(negedge Schreibsignal);
            if (o_done !== 1'b0) begin
                stopRun("An extra o_done pulse followed a start that should be ignored");
            end
        end
    endtask

    task automatic testIllegal();
        checkOp(funcCode_t'(6'd32), 32'h1111_2222, 32'h3333_4444);
        checkOp(funcCode_t'(6'd12), 32'h1111_2222, 32'h3333_4444);
        checkOp(funcCode_t'(6'd63), 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        // Next legal code clears the flag
        checkOp(FnAdd, 32'd2, 32'd3);
        checkOp(funcCode_t'(6'd40), 32'd5, 32'd6);
        checkOp(FnDiv, 32'd100, 32'd7);
    endtask

    initial begin
        Schreibsignal = 1'b0;
        i_rst         = 1'b1;
        i_start       = 1'b0;
        i_funcCode    = FnAdd;
        i_opA         = '0;
        i_opB         = '0;
        seed          = 32'h1c145870;

        repeat (3) @(posedge Schreibsignal);
        i_rst <= 1'b0;

        @(negedge Schreibsignal);
        checkFlag("o_done", o_done, 1'b0);
        checkFlag("o_busy", o_busy, 1'b0);
        checkFlag("o_illegal", o_illegal, 1'b0);
        checkWord("o_result", o_result, 32'd0);

        testOneCycle();
        testRotates();
        testDivide();
        testSqrt();
        testStartWhileBusy();
        testIllegal();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  wire                    Schreibsignal,
    input  wire                    i_rst,
    input  wire                    i_start,
    input  wire aluPkg::funcCode_t i_funcCode,
    input  wire aluPkg::word_t     i_opA,
    input  wire aluPkg::word_t     i_opB,
    output aluPkg::word_t          o_result,
    output logic                   o_done,
    output logic                   o_busy,
    output logic                   o_illegal
);

    import aluPkg::*;

    typedef enum logic {
        StIdle,
        StWait
    } state_t;

    state_t    state;
    funcCode_t runCode;

    word_t     simpleResult;
    logic      simpleIllegal;
    word_t     rotResult;

    logic      accept;
    logic      isRotate;
    logic      isDivide;
    logic      isSqrt;

    logic      divStart;
    logic      divDone;
    word_t     quotient;
    word_t     remainder;
    logic      sqrtStart;
    logic      sqrtDone;
    word_t     root;

    assign accept   = i_start && (state == StIdle);
    assign isRotate = (i_funcCode == FnRotl) || (i_funcCode == FnRotr);
    assign isDivide = (i_funcCode == FnDiv) || (i_funcCode == FnMod);
    assign isSqrt   = (i_funcCode == FnSqrt);

    // Iterative units latch the operands on the accepting edge
    assign divStart  = accept && isDivide;
    assign sqrtStart = accept && isSqrt;

    simpleOps u_simpleOps (
        .i_funcCode (i_funcCode),
        .i_opA      (i_opA),
        .i_opB      (i_opB),
        .o_result   (simpleResult),
        .o_illegal  (simpleIllegal)
    );

    rotator #(
        .Width (aluPkg::WordWidth)
    ) u_rotator (
        .i_data   (i_opA),
        .i_amount (i_opB[$bits(shamt_t)-1:0]),
        .i_right  (i_funcCode == FnRotr),
        .o_data   (rotResult)
    );

    intDivider #(
        .Width (aluPkg::WordWidth)
    ) u_intDivider (
        .Schreibsignal (Schreibsignal),
        .i_rst         (i_rst),
        .i_start       (divStart),
        .i_dividend    (i_opA),
        .i_divisor     (i_opB),
        .o_quotient    (quotient),
        .o_remainder   (remainder),
        .o_done        (divDone)
    );

    intSqrt #(
        .Width (aluPkg::WordWidth)
    ) u_intSqrt (
        .Schreibsignal (Schreibsignal),
        .i_rst         (i_rst),
        .i_start       (sqrtStart),
        .i_radicand    (i_opA),
        .o_root        (root),
        .o_done        (sqrtDone)
    );

    always_ff @(posedge Schreibsignal) begin
        if (i_rst) begin
            state     <= StIdle;
            runCode   <= FnAdd;
            o_result  <= '0;
            o_done    <= 1'b0;
            o_busy    <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                StIdle: begin
                    if (i_start) begin
                        runCode <= i_funcCode;
                        if (isDivide || isSqrt) begin
                            state  <= StWait;
                            o_busy <= 1'b1;
                        end else begin
                            // One-cycle codes and illegal codes finish here
                            o_result  <= isRotate ? rotResult : simpleResult;
                            o_illegal <= simpleIllegal;
                            o_done    <= 1'b1;
                        end
                    end
                end
                StWait: begin
                    if (divDone || sqrtDone) begin
                        state     <= StIdle;
                        o_busy    <= 1'b0;
                        o_done    <= 1'b1;
                        o_illegal <= 1'b0;
                        case (runCode)
                            FnSqrt:  o_result <= root;
                            FnMod:   o_result <= remainder;
                            default: o_result <= quotient;
                        endcase
                    end
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

    // busy drops on the same edge that raises done
    doneNotBusy: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        o_done |-> !o_busy
    );

    acceptNotBusy: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        accept |-> !o_busy
    );

    doneOneCycle: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        o_done |=> !o_done
    );

endmodule

`default_nettype wire

//--- logic/intSqrt.sv
`default_nettype none

module intSqrt #(
    parameter int Width = 32
) (
    input  wire                Schreibsignal,
    input  wire                i_rst,
    input  wire                i_start,
    input  wire aluPkg::word_t i_radicand,
    output aluPkg::word_t      o_root,
    output logic               o_done
);

    localparam int RootWidth  = Width / 2;
    localparam int RemWidth   = RootWidth + 3;
    localparam int CountWidth = $clog2(RootWidth);

    typedef enum logic [1:0] {
        StIdle,
        StRun,
        StFinish
    } state_t;

    state_t                state;
    logic [CountWidth-1:0] count;
    logic                  lastStep;

    logic [Width-1:0]      radicand;
    logic [RootWidth-1:0]  root;
    logic [RemWidth-1:0]   remainder;
    logic [RemWidth-1:0]   shiftedRem;
    logic [RemWidth-1:0]   trial;
    logic                  fits;

    // Bring down the next two radicand bits, try 4*root+1
    assign shiftedRem = {remainder[RemWidth-3:0], radicand[Width-1 -: 2]};
    assign trial      = {1'b0, root, 2'b01};
    assign fits       = (shiftedRem >= trial);
    assign lastStep   = (count == CountWidth'(RootWidth - 1));

    always_ff @(posedge Schreibsignal) begin
        if (i_rst) begin
            state  <= StIdle;
            count  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                StIdle: begin
                    if (i_start) begin
                        state <= StRun;
                        count <= '0;
                    end
                end
                StRun: begin
                    count <= count + 1'b1;
                    if (lastStep) begin
                        state  <= StFinish;
                        o_done <= 1'b1;
                    end
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Schreibsignal) begin
        if (state == StIdle && i_start) begin
            radicand  <= i_radicand[Width-1:0];
            root      <= '0;
            remainder <= '0;
        end else if (state == StRun) begin
            radicand  <= radicand << 2;
            root      <= {root[RootWidth-2:0], fits};
            remainder <= fits ? (shiftedRem - trial) : shiftedRem;
        end
    end

    assign o_root = {{(Width - RootWidth){1'b0}}, root};

    donePulse: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        o_done |=> !o_done
    );

endmodule

`default_nettype wire

//--- logic/intDivider.sv
`default_nettype none

module intDivider #(
    parameter int Width = 32
) (
    input  wire                Schreibsignal,
    input  wire                i_rst,
    input  wire                i_start,
    input  wire aluPkg::word_t i_dividend,
    input  wire aluPkg::word_t i_divisor,
    output aluPkg::word_t      o_quotient,
    output aluPkg::word_t      o_remainder,
    output logic               o_done
);

    localparam int CountWidth = $clog2(Width);

    typedef enum logic [1:0] {
        StIdle,
        StRun,
        StFinish
    } state_t;

    state_t                state;
    logic [CountWidth-1:0] count;
    logic                  lastStep;

    logic [Width-1:0]      divisor;
    logic [Width-1:0]      quotient;
    logic [Width-1:0]      remainder;
    logic [Width:0]        partial;
    logic [Width:0]        difference;

    // Next dividend bit enters the partial remainder from the quotient MSB
    assign partial    = {remainder, quotient[Width-1]};
    assign difference = partial - {1'b0, divisor};
    assign lastStep   = (count == CountWidth'(Width - 1));

    always_ff @(posedge Schreibsignal) begin
        if (i_rst) begin
            state  <= StIdle;
            count  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                StIdle: begin
                    if (i_start) begin
                        state <= StRun;
                        count <= '0;
                    end
                end
                StRun: begin
                    count <= count + 1'b1;
                    if (lastStep) begin
                        state  <= StFinish;
                        o_done <= 1'b1;
                    end
                end
                StFinish: begin
                    state <= StIdle;
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

    // One restoring step per cycle.
    // A zero divisor never fails the subtract, so the quotient fills with ones
    // and the remainder ends up holding the dividend
    always_ff @(posedge Schreibsignal) begin
        if (state == StIdle && i_start) begin
            quotient  <= i_dividend[Width-1:0];
            divisor   <= i_divisor[Width-1:0];
            remainder <= '0;
        end else if (state == StRun) begin
            if (!difference[Width]) begin
                remainder <= difference[Width-1:0];
                quotient  <= {quotient[Width-2:0], 1'b1};
            end else begin
                remainder <= partial[Width-1:0];
                quotient  <= {quotient[Width-2:0], 1'b0};
            end
        end
    end

    assign o_quotient  = quotient;
    assign o_remainder = remainder;

    doneInFinish: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        o_done |-> state == StFinish
    );

    // The caller waits for done before the next start
    startOnlyWhenIdle: assert property (
        @(posedge Schreibsignal) disable iff (i_rst)
        i_start |-> state == StIdle
    );

endmodule

`default_nettype wire

//--- logic/simpleOps.sv
`default_nettype none

module simpleOps (
    input  wire aluPkg::funcCode_t i_funcCode,
    input  wire aluPkg::word_t     i_opA,
    input  wire aluPkg::word_t     i_opB,
    output aluPkg::word_t          o_result,
    output logic                   o_illegal
);

    import aluPkg::*;

    word_t sum;
    word_t difference;
    word_t product;
    word_t leftShift;
    word_t rightShift;
    logic  shiftTooFar;

    // Arithmetic wraps at the word width
    assign sum        = i_opA + i_opB;
    assign difference = i_opA - i_opB;

    // Only the low word of the product is kept
    assign product = i_opA * i_opB;

    // Whole operand B is the shift amount
    assign shiftTooFar = (i_opB >= word_t'(WordWidth));
    assign leftShift   = shiftTooFar ? '0 : (i_opA << i_opB[$bits(shamt_t)-1:0]);
    assign rightShift  = shiftTooFar ? '0 : (i_opA >> i_opB[$bits(shamt_t)-1:0]);

    always_comb begin
        o_result  = '0;
        o_illegal = 1'b0;
        case (i_funcCode)
            FnAdd: o_result = sum;
            FnSub: o_result = difference;
            FnMul: o_result = product;

            FnShl: o_result = leftShift;
            FnShr: o_result = rightShift;

            // Unsigned compares, result is 0 or 1
            FnEq: o_result = word_t'(i_opA == i_opB);
            FnNe: o_result = word_t'(i_opA != i_opB);
            FnGt: o_result = word_t'(i_opA > i_opB);
            FnGe: o_result = word_t'(i_opA >= i_opB);
            FnLt: o_result = word_t'(i_opA < i_opB);
            FnLe: o_result = word_t'(i_opA <= i_opB);

            FnNot:  o_result = ~i_opA;
            FnAnd:  o_result = i_opA & i_opB;
            FnOr:   o_result = i_opA | i_opB;
            FnXor:  o_result = i_opA ^ i_opB;
            FnXnor: o_result = i_opA ~^ i_opB;

            // Legal, but the result comes from the rotator or an iterative unit
            FnSqrt, FnDiv, FnMod, FnRotl, FnRotr: begin
                o_result = '0;
            end

            // Float branch and unlisted codes
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rotator.sv
`default_nettype none

module rotator #(
    parameter int Width = 32
) (
    input  wire aluPkg::word_t  i_data,
    input  wire aluPkg::shamt_t i_amount,
    input  wire                 i_right,
    output aluPkg::word_t       o_data
);

    localparam int DoubleWidth = 2 * Width;

    logic [DoubleWidth-1:0] doubled;
    logic [DoubleWidth-1:0] shifted;
    int                     distance;

    // Distances at or beyond the width wrap around
    assign distance = int'(i_amount) % Width;

    // Two copies side by side, so bits leaving one end show up at the other
    assign doubled = {i_data[Width-1:0], i_data[Width-1:0]};

    always_comb begin
        if (i_right) begin
            shifted = doubled >> distance;
        end else begin
            shifted = doubled << distance;
        end
    end

    // Right rotate lands in the low half, left rotate in the high half
    assign o_data = i_right ? shifted[Width-1:0] : shifted[DoubleWidth-1:Width];

endmodule

`default_nettype wire

//--- logic/aluPkg.sv
`default_nettype none

package aluPkg;

    // Data path width of the whole unit
    localparam int WordWidth = 32;

    // Operand and result word
    typedef logic [WordWidth-1:0] word_t;

    // Rotate distance from the low bits of operand B
    typedef logic [$clog2(WordWidth)-1:0] shamt_t;

    // Function codes, anything not listed is illegal
    typedef enum logic [5:0] {
        FnAdd  = 6'd0,
        FnSub  = 6'd1,
        FnMul  = 6'd2,
        FnSqrt = 6'd3,
        FnDiv  = 6'd4,
        FnMod  = 6'd5,
        FnShl  = 6'd6,
        FnShr  = 6'd7,
        FnRotl = 6'd8,
        FnRotr = 6'd9,
        FnEq   = 6'd16,
        FnNe   = 6'd17,
        FnGt   = 6'd18,
        FnGe   = 6'd19,
        FnLt   = 6'd20,
        FnLe   = 6'd21,
        FnNot  = 6'd24,
        FnAnd  = 6'd25,
        FnOr   = 6'd26,
        FnXor  = 6'd27,
        FnXnor = 6'd28
    } funcCode_t;

endpackage

`default_nettype wire
